/* design/pkt_pkg.sv */
package pkt_pkg;

    // Data word and byte count
    localparam int DATA_W = 32;
    // Holds 1 to 4 valid bytes
    localparam int BYTES_W = 3;
    // Word address inside one packet, at most 64 words
    localparam int ADDR_W = 6;

    // Filter cores and the tag that names one of them
    localparam int N_CORES = 4;
    localparam int TAG_W = 2;

    // Result fields
    localparam int LEN_W = 9;
    localparam int SUM_W = 16;

    // Length rule in bytes, both bounds pass
    localparam int MIN_LEN = 8;
    localparam int MAX_LEN = 200;

    // Snooper FSM
    typedef enum logic [1:0] {
        SN_IDLE,
        SN_CLAIM,
        SN_STREAM,
        SN_DONE
    } sn_state_t;

endpackage

/* design/tag_tree.sv */
`timescale 1ns/1ps

module tag_tree (
    input  logic [pkt_pkg::N_CORES-1:0] rdy_in_i,
    input  logic                        ack_i,
    output logic [pkt_pkg::TAG_W-1:0]   tag_o,
    output logic                        rdy_o,
    output logic [pkt_pkg::N_CORES-1:0] ack_out_o
);

    // Heap layout, node 1 is the root and node k has children 2k and 2k+1
    // Leaves sit at N_CORES .. 2*N_CORES-1
    logic                      node_rdy [1:2*pkt_pkg::N_CORES-1];
    logic [pkt_pkg::TAG_W-1:0] node_tag [1:2*pkt_pkg::N_CORES-1];

    always_comb begin
        // Leaves carry their own core index
        for (int i = 0; i < pkt_pkg::N_CORES; i++) begin
            node_rdy[pkt_pkg::N_CORES + i] = rdy_in_i[i];
            node_tag[pkt_pkg::N_CORES + i] = i[pkt_pkg::TAG_W-1:0];
        end
        // Reduce pairs from the bottom level up
        for (int k = pkt_pkg::N_CORES - 1; k >= 1; k--) begin
            node_rdy[k] = node_rdy[2*k] | node_rdy[2*k+1];
            // Left child holds the lower indices, so it wins a tie
            if (node_rdy[2*k]) begin
                node_tag[k] = node_tag[2*k];
            end else begin
                node_tag[k] = node_tag[2*k+1];
            end
        end
    end

    // Any ready core makes the tree ready
    assign rdy_o = node_rdy[1];
    assign tag_o = node_tag[1];

    // One-hot claim toward the winner, only on a completed handshake
    always_comb begin
        ack_out_o = '0;
        ack_out_o[tag_o] = ack_i & rdy_o;
    end

endmodule

/* design/pkt_snooper.sv */
`timescale 1ns/1ps

module pkt_snooper (
    input  logic                        clk,
    input  logic                        rst,
    input  logic                        in_valid_i,
    input  logic [pkt_pkg::DATA_W-1:0]  in_data_i,
    input  logic [pkt_pkg::BYTES_W-1:0] in_bytes_i,
    input  logic                        in_last_i,
    input  logic                        rdy_i,
    output logic                        in_ready_o,
    output logic                        ack_o,
    output logic [pkt_pkg::ADDR_W-1:0]  addr_o,
    output logic [pkt_pkg::DATA_W-1:0]  wr_data_o,
    output logic                        wr_en_o,
    output logic [pkt_pkg::BYTES_W-1:0] byte_inc_o,
    output logic                        done_o
);

    pkt_pkg::sn_state_t        state;
    pkt_pkg::sn_state_t        state_nxt;
    logic [pkt_pkg::ADDR_W-1:0] addr_q;

    always_comb begin
        state_nxt = state;
        case (state)
            // First word is seen but held at the input
            pkt_pkg::SN_IDLE: begin
                if (in_valid_i) begin
                    state_nxt = pkt_pkg::SN_CLAIM;
                end
            end
            // Stay here until some core is free
            pkt_pkg::SN_CLAIM: begin
                if (rdy_i) begin
                    state_nxt = pkt_pkg::SN_STREAM;
                end
            end
            pkt_pkg::SN_STREAM: begin
                if (in_valid_i && in_last_i) begin
                    state_nxt = pkt_pkg::SN_DONE;
                end
            end
            // Done pulse lasts one cycle
            default: state_nxt = pkt_pkg::SN_IDLE;
        endcase
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            state <= pkt_pkg::SN_IDLE;
            addr_q <= '0;
        end else begin
            state <= state_nxt;
            // Address restarts at zero for every claimed packet
            if (state == pkt_pkg::SN_CLAIM) begin
                addr_q <= '0;
            end else if (wr_en_o) begin
                addr_q <= addr_q + pkt_pkg::ADDR_W'(1);
            end
        end
    end

    // Words pass straight through while streaming
    assign in_ready_o = (state == pkt_pkg::SN_STREAM);
    assign wr_en_o = in_ready_o & in_valid_i;
    assign ack_o = (state == pkt_pkg::SN_CLAIM);
    assign done_o = (state == pkt_pkg::SN_DONE);
    assign addr_o = addr_q;
    assign wr_data_o = in_data_i;
    assign byte_inc_o = in_bytes_i;

    // No write outside streaming and never together with done
    assert property (@(posedge clk) disable iff (rst)
        wr_en_o |-> state == pkt_pkg::SN_STREAM && !done_o);

    // A word that is not taken stays on the input unchanged
    assert property (@(posedge clk) disable iff (rst)
        in_valid_i && !in_ready_o |=> in_valid_i && $stable(in_data_i) && $stable(in_last_i));

endmodule

/* design/snoop_arb.sv */
`timescale 1ns/1ps

module snoop_arb #(
    parameter bit PESS = 1'b0
) (
    input  logic                        clk,
    input  logic                        rst,
    input  logic [pkt_pkg::ADDR_W-1:0]  addr_i,
    input  logic [pkt_pkg::DATA_W-1:0]  wr_data_i,
    input  logic                        wr_en_i,
    input  logic [pkt_pkg::BYTES_W-1:0] byte_inc_i,
    input  logic                        done_i,
    input  logic                        ack_i,
    input  logic [pkt_pkg::N_CORES-1:0] rdy_for_sn_i,
    output logic                        rdy_o,
    output logic [pkt_pkg::ADDR_W-1:0]  sn_addr_o,
    output logic [pkt_pkg::DATA_W-1:0]  sn_wr_data_o,
    output logic [pkt_pkg::N_CORES-1:0] sn_wr_en_o,
    output logic [pkt_pkg::BYTES_W-1:0] sn_byte_inc_o,
    output logic [pkt_pkg::N_CORES-1:0] sn_done_o,
    output logic [pkt_pkg::N_CORES-1:0] rdy_for_sn_ack_o
);

    logic [pkt_pkg::TAG_W-1:0]   sel_next;
    logic [pkt_pkg::TAG_W-1:0]   sel_q;
    logic [pkt_pkg::N_CORES-1:0] ack_out;
    logic [pkt_pkg::N_CORES-1:0] wr_en_hot;
    logic [pkt_pkg::N_CORES-1:0] done_hot;

    // Picks the lowest free core and drives the one-hot claim
    tag_tree u_tag_tree (
        .rdy_in_i (rdy_for_sn_i),
        .ack_i    (ack_i),
        .tag_o    (sel_next),
        .rdy_o    (rdy_o),
        .ack_out_o(ack_out)
    );

    // Selection is taken on the edge that completes a claim
    always_ff @(posedge clk) begin
        if (rst) begin
            sel_q <= '0;
        end else if (rdy_o && ack_i) begin
            sel_q <= sel_next;
        end
    end

    // Only enable and done are gated, the payload fans out to all cores
    always_comb begin
        for (int i = 0; i < pkt_pkg::N_CORES; i++) begin
            wr_en_hot[i] = wr_en_i && (sel_q == i[pkt_pkg::TAG_W-1:0]);
            done_hot[i] = done_i && (sel_q == i[pkt_pkg::TAG_W-1:0]);
        end
    end

    generate
        if (PESS) begin : g_pess
            // Extra stage on every core-side output to ease fanout
            always_ff @(posedge clk) begin
                sn_addr_o <= addr_i;
                sn_wr_data_o <= wr_data_i;
                sn_byte_inc_o <= byte_inc_i;
            end
            always_ff @(posedge clk) begin
                if (rst) begin
                    sn_wr_en_o <= '0;
                    sn_done_o <= '0;
                    rdy_for_sn_ack_o <= '0;
                end else begin
                    sn_wr_en_o <= wr_en_hot;
                    sn_done_o <= done_hot;
                    rdy_for_sn_ack_o <= ack_out;
                end
            end
        end else begin : g_direct
            assign sn_addr_o = addr_i;
            assign sn_wr_data_o = wr_data_i;
            assign sn_byte_inc_o = byte_inc_i;
            assign sn_wr_en_o = wr_en_hot;
            assign sn_done_o = done_hot;
            assign rdy_for_sn_ack_o = ack_out;
        end
    endgenerate

    // At most one core is written, and never one that still reports ready
    assert property (@(posedge clk) disable iff (rst)
        $onehot0(sn_wr_en_o) && (sn_wr_en_o & rdy_for_sn_i) == '0);

endmodule

/* design/filter_core.sv */
`timescale 1ns/1ps

module filter_core (
    input  logic                        clk,
    input  logic                        rst,
    input  logic [pkt_pkg::ADDR_W-1:0]  sn_addr_i,
    input  logic [pkt_pkg::DATA_W-1:0]  sn_wr_data_i,
    input  logic                        sn_wr_en_i,
    input  logic [pkt_pkg::BYTES_W-1:0] sn_byte_inc_i,
    input  logic                        sn_done_i,
    input  logic                        claim_i,
    input  logic                        res_take_i,
    output logic                        rdy_for_sn_o,
    output logic                        res_valid_o,
    output logic [7:0]                  res_id_o,
    output logic [pkt_pkg::LEN_W-1:0]   res_len_o,
    output logic [pkt_pkg::SUM_W-1:0]   res_sum_o,
    output logic                        res_pass_o
);

    logic                       claimed_q;
    logic                       valid_q;
    logic [7:0]                 id_q;
    logic [pkt_pkg::LEN_W-1:0]  len_q;
    logic [pkt_pkg::SUM_W-1:0]  sum_q;
    logic                       pass_q;
    logic [pkt_pkg::SUM_W-1:0]  word_sum;

    // Sum of the valid bytes in this word, top byte first
    always_comb begin
        word_sum = '0;
        for (int b = 0; b < pkt_pkg::DATA_W / 8; b++) begin
            if (b < int'(sn_byte_inc_i)) begin
                word_sum = word_sum
                    + pkt_pkg::SUM_W'(sn_wr_data_i[pkt_pkg::DATA_W-1-8*b -: 8]);
            end
        end
    end

    // Claim and result flags
    always_ff @(posedge clk) begin
        if (rst) begin
            claimed_q <= 1'b0;
            valid_q <= 1'b0;
        end else begin
            if (claim_i) begin
                claimed_q <= 1'b1;
            end else if (sn_done_i) begin
                claimed_q <= 1'b0;
            end
            if (sn_done_i) begin
                valid_q <= 1'b1;
            end else if (res_take_i) begin
                valid_q <= 1'b0;
            end
        end
    end

    // Packet fields, cleared at claim and held until the next claim
    always_ff @(posedge clk) begin
        if (claim_i) begin
            len_q <= '0;
            sum_q <= '0;
        end else if (sn_wr_en_i) begin
            len_q <= len_q + pkt_pkg::LEN_W'(sn_byte_inc_i);
            // Checksum wraps modulo 2^16
            sum_q <= sum_q + word_sum;
        end
        // Packet id is the top byte of word 0
        if (sn_wr_en_i && sn_addr_i == '0) begin
            id_q <= sn_wr_data_i[pkt_pkg::DATA_W-1 -: 8];
        end
        // Length is final by done, since done trails the last write
        if (sn_done_i) begin
            pass_q <= (len_q >= pkt_pkg::LEN_W'(pkt_pkg::MIN_LEN))
                   && (len_q <= pkt_pkg::LEN_W'(pkt_pkg::MAX_LEN));
        end
    end

    // Busy from claim until the collector has taken the result
    assign rdy_for_sn_o = !claimed_q && !valid_q;
    assign res_valid_o = valid_q;
    assign res_id_o = id_q;
    assign res_len_o = len_q;
    assign res_sum_o = sum_q;
    assign res_pass_o = pass_q;

    // Arbiter only routes writes and done to the core it claimed
    assert property (@(posedge clk) disable iff (rst)
        (sn_wr_en_i || sn_done_i) |-> claimed_q);

endmodule

/* design/result_collector.sv */
`timescale 1ns/1ps

module result_collector (
    input  logic                                           clk,
    input  logic                                           rst,
    input  logic [pkt_pkg::N_CORES-1:0]                    core_valid_i,
    input  logic [pkt_pkg::N_CORES-1:0][7:0]               core_id_i,
    input  logic [pkt_pkg::N_CORES-1:0][pkt_pkg::LEN_W-1:0] core_len_i,
    input  logic [pkt_pkg::N_CORES-1:0][pkt_pkg::SUM_W-1:0] core_sum_i,
    input  logic [pkt_pkg::N_CORES-1:0]                    core_pass_i,
    input  logic                                           res_ready_i,
    output logic [pkt_pkg::N_CORES-1:0]                    core_take_o,
    output logic                                           res_valid_o,
    output logic [7:0]                                     res_id_o,
    output logic [pkt_pkg::LEN_W-1:0]                      res_len_o,
    output logic [pkt_pkg::SUM_W-1:0]                      res_sum_o,
    output logic                                           res_pass_o
);

    logic [pkt_pkg::TAG_W-1:0] rr_q;
    logic [pkt_pkg::TAG_W-1:0] idx;
    logic [pkt_pkg::TAG_W-1:0] pick;
    logic                      found;
    logic                      load;

    // First valid core at or after the round-robin pointer
    always_comb begin
        pick = rr_q;
        found = 1'b0;
        idx = rr_q;
        for (int i = 0; i < pkt_pkg::N_CORES; i++) begin
            idx = rr_q + i[pkt_pkg::TAG_W-1:0];
            if (!found && core_valid_i[idx]) begin
                pick = idx;
                found = 1'b1;
            end
        end
    end

    // Output register is empty or drains this cycle
    assign load = found && (!res_valid_o || res_ready_i);

    always_comb begin
        core_take_o = '0;
        core_take_o[pick] = load;
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            res_valid_o <= 1'b0;
            rr_q <= '0;
        end else if (load) begin
            res_valid_o <= 1'b1;
            // Next search starts past the core just served
            rr_q <= pick + pkt_pkg::TAG_W'(1);
        end else if (res_ready_i) begin
            res_valid_o <= 1'b0;
        end
    end

    always_ff @(posedge clk) begin
        if (load) begin
            res_id_o <= core_id_i[pick];
            res_len_o <= core_len_i[pick];
            res_sum_o <= core_sum_i[pick];
            res_pass_o <= core_pass_i[pick];
        end
    end

    // A core keeps its result until it is taken here
    assert property (@(posedge clk) disable iff (rst)
        ($past(core_valid_i & ~core_take_o) & ~core_valid_i) == '0);

endmodule

/* design/pkt_dispatch_top.sv */
`timescale 1ns/1ps

module pkt_dispatch_top (
    input  logic                        clk,
    input  logic                        rst,
    input  logic                        in_valid_i,
    input  logic [pkt_pkg::DATA_W-1:0]  in_data_i,
    input  logic [pkt_pkg::BYTES_W-1:0] in_bytes_i,
    input  logic                        in_last_i,
    output logic                        in_ready_o,
    output logic                        res_valid_o,
    input  logic                        res_ready_i,
    output logic [7:0]                  res_id_o,
    output logic [pkt_pkg::LEN_W-1:0]   res_len_o,
    output logic [pkt_pkg::SUM_W-1:0]   res_sum_o,
    output logic                        res_pass_o
);

    // Snooper to arbiter
    logic                        sn_ack;
    logic                        arb_rdy;
    logic [pkt_pkg::ADDR_W-1:0]  sn_addr;
    logic [pkt_pkg::DATA_W-1:0]  sn_wr_data;
    logic                        sn_wr_en;
    logic [pkt_pkg::BYTES_W-1:0] sn_byte_inc;
    logic                        sn_done;

    // Arbiter to cores
    logic [pkt_pkg::ADDR_W-1:0]  core_addr;
    logic [pkt_pkg::DATA_W-1:0]  core_wr_data;
    logic [pkt_pkg::N_CORES-1:0] core_wr_en;
    logic [pkt_pkg::BYTES_W-1:0] core_byte_inc;
    logic [pkt_pkg::N_CORES-1:0] core_done;
    logic [pkt_pkg::N_CORES-1:0] core_claim;
    logic [pkt_pkg::N_CORES-1:0] core_rdy;

    // Cores to collector
    logic [pkt_pkg::N_CORES-1:0]                     core_valid;
    logic [pkt_pkg::N_CORES-1:0]                     core_take;
    logic [pkt_pkg::N_CORES-1:0][7:0]                core_id;
    logic [pkt_pkg::N_CORES-1:0][pkt_pkg::LEN_W-1:0] core_len;
    logic [pkt_pkg::N_CORES-1:0][pkt_pkg::SUM_W-1:0] core_sum;
    logic [pkt_pkg::N_CORES-1:0]                     core_pass;

    pkt_snooper u_snooper (
        .clk       (clk),
        .rst       (rst),
        .in_valid_i(in_valid_i),
        .in_data_i (in_data_i),
        .in_bytes_i(in_bytes_i),
        .in_last_i (in_last_i),
        .rdy_i     (arb_rdy),
        .in_ready_o(in_ready_o),
        .ack_o     (sn_ack),
        .addr_o    (sn_addr),
        .wr_data_o (sn_wr_data),
        .wr_en_o   (sn_wr_en),
        .byte_inc_o(sn_byte_inc),
        .done_o    (sn_done)
    );

    snoop_arb #(
        .PESS(1'b0)
    ) u_arb (
        .clk             (clk),
        .rst             (rst),
        .addr_i          (sn_addr),
        .wr_data_i       (sn_wr_data),
        .wr_en_i         (sn_wr_en),
        .byte_inc_i      (sn_byte_inc),
        .done_i          (sn_done),
        .ack_i           (sn_ack),
        .rdy_for_sn_i    (core_rdy),
        .rdy_o           (arb_rdy),
        .sn_addr_o       (core_addr),
        .sn_wr_data_o    (core_wr_data),
        .sn_wr_en_o      (core_wr_en),
        .sn_byte_inc_o   (core_byte_inc),
        .sn_done_o       (core_done),
        .rdy_for_sn_ack_o(core_claim)
    );

    genvar c;
    generate
        for (c = 0; c < pkt_pkg::N_CORES; c++) begin : g_core
            filter_core u_core (
                .clk          (clk),
                .rst          (rst),
                .sn_addr_i    (core_addr),
                .sn_wr_data_i (core_wr_data),
                .sn_wr_en_i   (core_wr_en[c]),
                .sn_byte_inc_i(core_byte_inc),
                .sn_done_i    (core_done[c]),
                .claim_i      (core_claim[c]),
                .res_take_i   (core_take[c]),
                .rdy_for_sn_o (core_rdy[c]),
                .res_valid_o  (core_valid[c]),
                .res_id_o     (core_id[c]),
                .res_len_o    (core_len[c]),
                .res_sum_o    (core_sum[c]),
                .res_pass_o   (core_pass[c])
            );
        end
    endgenerate

    result_collector u_collector (
        .clk         (clk),
        .rst         (rst),
        .core_valid_i(core_valid),
        .core_id_i   (core_id),
        .core_len_i  (core_len),
        .core_sum_i  (core_sum),
        .core_pass_i (core_pass),
        .res_ready_i (res_ready_i),
        .core_take_o (core_take),
        .res_valid_o (res_valid_o),
        .res_id_o    (res_id_o),
        .res_len_o   (res_len_o),
        .res_sum_o   (res_sum_o),
        .res_pass_o  (res_pass_o)
    );

endmodule

/* tests/tb_pkt_dispatch.sv */
`timescale 1ns/1ps

module tb_pkt_dispatch;

    // Sink held off at the start so all cores fill and the snooper stalls
    localparam int HOLD_CYCLES = 60;

    logic                        clk = 1'b0;
    logic                        rst = 1'b1;
    logic                        in_valid_i = 1'b0;
    logic [pkt_pkg::DATA_W-1:0]  in_data_i = '0;
    logic [pkt_pkg::BYTES_W-1:0] in_bytes_i = '0;
    logic                        in_last_i = 1'b0;
    logic                        res_ready_i = 1'b0;
    logic                        in_ready_o;
    logic                        res_valid_o;
    logic [7:0]                  res_id_o;
    logic [pkt_pkg::LEN_W-1:0]   res_len_o;
    logic [pkt_pkg::SUM_W-1:0]   res_sum_o;
    logic                        res_pass_o;

    // Raw records and the word stream expanded from them
    logic [31:0]                 pat_mem [0:255];
    logic [31:0]                 tx_data [$];
    logic [pkt_pkg::BYTES_W-1:0] tx_bytes [$];
    logic                        tx_last [$];

    // Expected results, indexed by packet id
    bit          exp_known [0:255];
    bit          seen [0:255];
    logic [31:0] exp_len [0:255];
    logic [31:0] exp_sum [0:255];
    logic [31:0] exp_pass [0:255];

    int          n_pkts = 0;
    int          results_got = 0;
    int          value_errors = 0;
    int          other_errors = 0;
    int          word_idx = 0;
    int          offered_idx = -1;
    int          stim_cycles = 0;
    bit          stim_en = 1'b0;
    bit          idle_chk = 1'b0;
    logic [31:0] rnd = 32'h5c639fc6;

    pkt_dispatch_top UUT (
        .clk        (clk),
        .rst        (rst),
        .in_valid_i (in_valid_i),
        .in_data_i  (in_data_i),
        .in_bytes_i (in_bytes_i),
        .in_last_i  (in_last_i),
        .in_ready_o (in_ready_o),
        .res_valid_o(res_valid_o),
        .res_ready_i(res_ready_i),
        .res_id_o   (res_id_o),
        .res_len_o  (res_len_o),
        .res_sum_o  (res_sum_o),
        .res_pass_o (res_pass_o)
    );

    initial begin
        forever #5 clk = ~clk;
    end

    // Galois LFSR, one step per random bit
    function automatic logic [31:0] lfsr_step(input logic [31:0] s);
        if (s[0]) begin
            lfsr_step = (s >> 1) ^ 32'h80200003;
        end else begin
            lfsr_step = s >> 1;
        end
    endfunction

    task automatic compare(input string what, input logic [31:0] got, input logic [31:0] exp);
        if (got !== exp) begin
            value_errors++;
            $display("ERROR at %0t ns: %s is %0h, expected %0h", $time, what, got, exp);
        end
    endtask

    // Record layout: id, len, sum, pass, word count, last byte count, first word, step
    task automatic load_patterns();
        int          rec;
        int          nw;
        int          k;
        logic [7:0]  id;
        logic [31:0] base;
        logic [31:0] step;
        $readmemh("tests/pkt_patterns.txt", pat_mem);
        n_pkts = int'(pat_mem[0]);
        for (int p = 0; p < n_pkts; p++) begin
            rec = 1 + 8 * p;
            id = pat_mem[rec][7:0];
            exp_known[id] = 1'b1;
            exp_len[id] = pat_mem[rec + 1];
            exp_sum[id] = pat_mem[rec + 2];
            exp_pass[id] = pat_mem[rec + 3];
            nw = int'(pat_mem[rec + 4]);
            base = pat_mem[rec + 6];
            step = pat_mem[rec + 7];
            // Word k of a packet is first_word + k * step
            for (k = 0; k < nw; k++) begin
                tx_data.push_back(base + 32'(k) * step);
                tx_last.push_back(k == nw - 1);
                if (k == nw - 1) begin
                    tx_bytes.push_back(pkt_pkg::BYTES_W'(pat_mem[rec + 5]));
                end else begin
                    tx_bytes.push_back(pkt_pkg::BYTES_W'(4));
                end
            end
        end
    endtask

    // Stimulus on the falling edge
    always @(negedge clk) begin : drive
        logic g0;
        logic g1;
        if (stim_en) begin
            stim_cycles++;
            // Offered word stays until the snooper takes it
            if (!(in_valid_i && offered_idx == word_idx)) begin
                if (word_idx < tx_data.size()) begin
                    rnd = lfsr_step(rnd);
                    g0 = rnd[0];
                    rnd = lfsr_step(rnd);
                    g1 = rnd[0];
                    // Idle gap one time in four
                    if (g0 && g1) begin
                        in_valid_i <= 1'b0;
                    end else begin
                        in_valid_i <= 1'b1;
                        in_data_i <= tx_data[word_idx];
                        in_bytes_i <= tx_bytes[word_idx];
                        in_last_i <= tx_last[word_idx];
                        offered_idx <= word_idx;
                    end
                end else begin
                    in_valid_i <= 1'b0;
                end
            end
            if (stim_cycles < HOLD_CYCLES) begin
                res_ready_i <= 1'b0;
            end else begin
                rnd = lfsr_step(rnd);
                res_ready_i <= rnd[0];
            end
        end
    end

    // Handshakes and result checks on the rising edge
    always @(posedge clk) begin
        if (!rst) begin
            if (in_valid_i && in_ready_o) begin
                word_idx <= word_idx + 1;
            end
            if (idle_chk) begin
                compare("in_ready_o with no word offered", 32'(in_ready_o), 32'd0);
                compare("res_valid_o after reset", 32'(res_valid_o), 32'd0);
            end
            if (res_valid_o && res_ready_i) begin
                if (!exp_known[res_id_o]) begin
                    other_errors++;
                    $display("Result with unknown id %02h at %0t ns", res_id_o, $time);
                end else if (seen[res_id_o]) begin
                    other_errors++;
                    $display("Result for id %02h reported twice at %0t ns", res_id_o, $time);
                end else begin
                    compare($sformatf("id %02h length", res_id_o), 32'(res_len_o),
                        exp_len[res_id_o]);
                    compare($sformatf("id %02h checksum", res_id_o), 32'(res_sum_o),
                        exp_sum[res_id_o]);
                    compare($sformatf("id %02h verdict", res_id_o), 32'(res_pass_o),
                        exp_pass[res_id_o]);
                    seen[res_id_o] <= 1'b1;
                    results_got <= results_got + 1;
                end
            end
        end
    end

    initial begin
        int cycles;
        int limit;
        bit timed_out;
        bit setup_fail;
        cycles = 0;
        timed_out = 1'b0;
        setup_fail = 1'b0;
        load_patterns();
        if (n_pkts <= 0) begin
            setup_fail = 1'b1;
            $display("No packets could be read from the patterns file");
        end
        repeat (2) @(negedge clk);
        rst = 1'b0;
        // Quiet input for a few cycles after reset
        idle_chk = 1'b1;
        repeat (4) @(negedge clk);
        idle_chk = 1'b0;
        @(posedge clk);
        stim_en = 1'b1;
        limit = 40 * tx_data.size() + 200;
        while (results_got < n_pkts && cycles < limit) begin
            @(posedge clk);
            cycles++;
        end
        if (results_got < n_pkts) begin
            timed_out = 1'b1;
            $display("Timed out after %0d cycles with %0d of %0d results received",
                cycles, results_got, n_pkts);
        end else begin
            // Room for a stray duplicate to show up
            repeat (20) @(negedge clk);
        end
        $display("Results %0d of %0d, value errors %0d, other errors %0d",
            results_got, n_pkts, value_errors, other_errors + int'(timed_out) + int'(setup_fail));
        if (value_errors == 0 && other_errors == 0 && !timed_out && !setup_fail) begin
            $display("Testbench passed");
        end else begin
            $display("Testbench failed");
        end
        $finish;
    end

endmodule

/* tests/pkt_patterns.txt */
// Packet count, then one record per packet, all values hex
// id len sum pass nwords last_bytes first_word step (word k = first_word + k * step)
0E
// Short packets back to back, more than the four cores hold at once
11 00C 01FE 1 03 4 11223344 00000000
12 007 0025 0 02 3 12000001 00000000
13 008 0242 1 02 4 13FF0A05 00000000
14 001 0014 0 01 1 14808080 00000000
15 00E 0067 1 04 2 15010203 00000000
// Words that change along the packet
20 014 00DC 1 05 4 20000000 00010203
21 00A 0095 1 03 2 21100000 00000101
22 010 008E 1 04 4 22000000 01000000
// Upper length bound, the last one fills all 64 word addresses
16 0C8 3C8C 1 32 4 16406080 00000000
17 0C9 99FF 0 33 1 17FFFFFF 00000000
18 100 C3C0 0 40 4 18FEFDFC 00000000
// Tail of short packets
23 009 006F 1 03 1 23000102 00000000
24 004 0090 0 01 4 24242424 00000000
25 008 004B 1 02 4 25000000 00000001

/* build.f */
design/pkt_pkg.sv
design/tag_tree.sv
design/pkt_snooper.sv
design/snoop_arb.sv
design/filter_core.sv
design/result_collector.sv
design/pkt_dispatch_top.sv
tests/tb_pkt_dispatch.sv

/* run_sim.sh */
#!/usr/bin/env bash
# Build and run the packet dispatch testbench with Verilator, judge the log
cd "$(dirname "$0")" || exit 1
verilator --binary --timing --assert --top-module tb_pkt_dispatch -f build.f \
    || { echo "Verilator build failed"; exit 1; }
./obj_dir/Vtb_pkt_dispatch 2>&1 | tee sim.log
! grep -q "Testbench failed" sim.log && grep -q "Testbench passed" sim.log \
    && echo "Simulation result: PASS" \
    || { echo "Simulation result: FAIL"; exit 1; }
